// File: dcache_consts.svh
////////////////////////////////////////////////////////////////////////////
// width macros for the data cache hit stage: word, address, line, index,
// tag, offsets and ways
////////////////////////////////////////////////////////////////////////////
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// data word and physical address
`define DC_XLEN 32
`define DC_PLEN 32

// 128 bit lines, four words each
`define DC_BLK_BITS 128
`define DC_WAYS 2

// address split: tag | index | byte offset in line
`define DC_IDX_BITS 4
`define DC_BLK_OFFS_BITS 4
`define DC_DAT_OFFS_BITS 2
`define DC_TAG_BITS 24

`endif

// File: dcache_types_pkg.sv
////////////////////////////////////////////////////////////////////////////
// address, data, line, index, tag and way types of the data cache
////////////////////////////////////////////////////////////////////////////
`default_nettype none
`include "dcache_consts.svh"

package dcache_types_pkg;

  // core side
  typedef logic [`DC_PLEN-1:0] adr_t;
  typedef logic [`DC_XLEN-1:0] word_t;
  typedef logic [`DC_XLEN/8-1:0] word_be_t;

  // one cache line and its byte enables
  typedef logic [`DC_BLK_BITS-1:0] line_t;
  typedef logic [`DC_BLK_BITS/8-1:0] line_be_t;

  // address fields
  typedef logic [`DC_IDX_BITS-1:0] idx_t;
  typedef logic [`DC_TAG_BITS-1:0] tag_t;
  typedef logic [`DC_DAT_OFFS_BITS-1:0] offs_t;

  // one-hot way select
  typedef logic [`DC_WAYS-1:0] way_t;

endpackage

`default_nettype wire

// File: dcache_biu_pkg.sv
////////////////////////////////////////////////////////////////////////////
// bus interface command encoding
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package dcache_biu_pkg;

  // commands from the hit stage to the bus interface
  typedef enum logic [1:0] {
    NOP      = 2'd0,
    READWAY  = 2'd1,
    WRITEWAY = 2'd2
  } biucmd_e;

endpackage

`default_nettype wire

// File: wbuf_if.sv
////////////////////////////////////////////////////////////////////////////
// write buffer contents shared between the buffer and its readers
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

interface wbuf_if;
  import dcache_types_pkg::*;

  logic     we;
  idx_t     idx;
  offs_t    offs;
  word_t    data;
  // already shifted to the word position in the line
  line_be_t be;

  modport owner  (output we, idx, offs, data, be);
  modport reader (input  we, idx, offs, data, be);

endinterface

`default_nettype wire

// File: dcache_hit_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// hit stage control: miss FSM, stall and latchmem, registered acknowledge
// and exception flags
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "dcache_consts.svh"

module dcache_hit_ctrl (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  input  wire logic                    flush_i,
  input  wire logic                    req_i,
  input  wire logic                    wreq_i,
  input  wire logic                    cacheable_i,
  input  wire logic                    misaligned_i,
  input  wire logic                    pma_exception_i,
  input  wire logic                    pmp_exception_i,
  input  wire logic                    pagefault_i,
  input  wire logic                    cache_hit_i,
  input  wire logic                    way_dirty_i,
  input  wire dcache_types_pkg::way_t  fill_way_i,
  input  wire logic                    biucmd_ack_i,
  input  wire logic                    biucmd_busy_i,
  input  wire logic                    biu_ack_i,
  input  wire logic                    biu_err_i,
  input  wire dcache_types_pkg::adr_t  adr_i,
  input  wire dcache_types_pkg::adr_t  biu_adro_i,
  output logic                         stall_o,
  output logic                         latchmem_o,
  output logic                         ack_o,
  output logic                         armed_o,
  output logic                         filling_o,
  output dcache_types_pkg::way_t       fill_way_o,
  output dcache_biu_pkg::biucmd_e      biucmd_o,
  output logic                         err_o,
  output logic                         misaligned_o,
  output logic                         pagefault_o,
  output logic                         wb_capture_o,
  output logic                         evict_capture_o
);
  import dcache_types_pkg::*;
  import dcache_biu_pkg::*;

  // byte position inside a word
  localparam int BYTE_OFFS_BITS = `DC_BLK_OFFS_BITS - `DC_DAT_OFFS_BITS;

  typedef enum logic [2:0] {
    ARMED    = 3'd0,
    EVICT    = 3'd1,
    READ     = 3'd2,
    RECOVER0 = 3'd3,
    RECOVER1 = 3'd4
  } state_e;

  state_e  state;
  state_e  nxt_state;
  biucmd_e nxt_biucmd;
  way_t    nxt_fill_way;
  logic    valid_req;
  logic    adr_match;
  logic    biu_hit_ack;
  logic    cache_ack;

  assign valid_req = req_i & ~pma_exception_i & ~pmp_exception_i &
                     ~misaligned_i & ~pagefault_i;

  // bus is returning the word the core asks for
  assign adr_match   = biu_adro_i[`DC_PLEN-1:BYTE_OFFS_BITS] ==
                       adr_i[`DC_PLEN-1:BYTE_OFFS_BITS];
  assign biu_hit_ack = valid_req & biu_ack_i & adr_match;
  assign cache_ack   = valid_req & cacheable_i & cache_hit_i & ~flush_i;

  assign wb_capture_o    = (state == ARMED) & valid_req & wreq_i &
                           cacheable_i & cache_hit_i;
  assign evict_capture_o = (state == ARMED);

  //////////////////////////////////////////////////////////////////////////
  // miss FSM
  //////////////////////////////////////////////////////////////////////////
  always_comb begin
    nxt_state    = state;
    nxt_biucmd   = NOP;
    nxt_fill_way = fill_way_o;

    case (state)
      ARMED: begin
        if (valid_req && cacheable_i && !cache_hit_i && !flush_i && !biucmd_busy_i) begin
          // refill into the way picked by the replacement logic
          nxt_fill_way = fill_way_i;
          nxt_biucmd   = READWAY;
          nxt_state    = way_dirty_i ? EVICT : READ;
        end
      end
      EVICT: begin
        if (biucmd_ack_i || biu_err_i) begin
          // new line is in, now write back the victim
          nxt_state  = RECOVER0;
          nxt_biucmd = WRITEWAY;
        end
      end
      READ: begin
        if (biucmd_ack_i || biu_err_i) begin
          nxt_state = RECOVER0;
        end
      end
      RECOVER0: nxt_state = RECOVER1;
      RECOVER1: nxt_state = ARMED;
      default:  nxt_state = ARMED;
    endcase
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state      <= ARMED;
      biucmd_o   <= NOP;
      fill_way_o <= '0;
      armed_o    <= 1'b1;
      filling_o  <= 1'b0;
    end else begin
      state      <= nxt_state;
      biucmd_o   <= nxt_biucmd;
      fill_way_o <= nxt_fill_way;
      armed_o    <= (nxt_state == ARMED);
      filling_o  <= (nxt_state == READ) || (nxt_state == EVICT);
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // stall and latchmem
  //////////////////////////////////////////////////////////////////////////
  always_comb begin
    case (state)
      ARMED: begin
        stall_o    = valid_req & cacheable_i & ~cache_hit_i;
        latchmem_o = ~stall_o;
      end
      READ, EVICT: begin
        // hit under miss, or the requested word comes off the bus
        stall_o    = ~(biu_hit_ack | (valid_req & cache_hit_i));
        latchmem_o = ~stall_o;
      end
      // index set up for tag and data memories
      RECOVER0: begin
        stall_o    = 1'b1;
        latchmem_o = 1'b0;
      end
      // memory outputs latched
      RECOVER1: begin
        stall_o    = 1'b1;
        latchmem_o = 1'b1;
      end
      default: begin
        stall_o    = 1'b0;
        latchmem_o = 1'b1;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////////
  // acknowledge and exceptions
  //////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      ack_o        <= 1'b0;
      err_o        <= 1'b0;
      misaligned_o <= 1'b0;
      pagefault_o  <= 1'b0;
    end else begin
      case (state)
        ARMED:       ack_o <= cache_ack;
        READ, EVICT: ack_o <= (biu_hit_ack & ~flush_i) | cache_ack;
        default:     ack_o <= 1'b0;
      endcase
      err_o        <= biu_err_i | (req_i & (pma_exception_i | pmp_exception_i));
      misaligned_o <= req_i & misaligned_i;
      pagefault_o  <= pagefault_i;
    end
  end

  a_state_legal : assert property (@(posedge clk_i) disable iff (!rst_ni)
    state inside {ARMED, EVICT, READ, RECOVER0, RECOVER1});

  // one read command per miss
  a_readway_single : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (biucmd_o == READWAY) |=> (biucmd_o != READWAY));

endmodule

`default_nettype wire

// File: dcache_wbuf.sv
////////////////////////////////////////////////////////////////////////////
// write buffer: captures a write hit and holds it until acknowledged
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "dcache_consts.svh"

module dcache_wbuf (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  input  wire logic                      flush_i,
  input  wire logic                      wb_capture_i,
  input  wire logic                      writebuffer_ack_i,
  input  wire dcache_types_pkg::adr_t    adr_i,
  input  wire dcache_types_pkg::word_t   d_i,
  input  wire dcache_types_pkg::word_be_t be_i,
  input  wire dcache_types_pkg::way_t    ways_hit_i,
  output dcache_types_pkg::way_t         ways_hit_o,
  wbuf_if.owner                          wb
);
  import dcache_types_pkg::*;

  offs_t offs;

  assign offs = adr_i[`DC_BLK_OFFS_BITS-1 -: `DC_DAT_OFFS_BITS];

  // pipeline flush wins over a new capture
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      wb.we <= 1'b0;
    end else if (flush_i) begin
      wb.we <= 1'b0;
    end else if (wb_capture_i) begin
      wb.we <= 1'b1;
    end else if (writebuffer_ack_i) begin
      wb.we <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wb_capture_i) begin
      wb.idx     <= adr_i[`DC_BLK_OFFS_BITS +: `DC_IDX_BITS];
      wb.offs    <= offs;
      wb.data    <= d_i;
      // byte enables moved to the word slot in the line
      wb.be      <= line_be_t'(be_i) << (offs * (`DC_XLEN / 8));
      ways_hit_o <= ways_hit_i;
    end
  end

  a_no_overwrite : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wb_capture_i && wb.we) |-> (flush_i || writebuffer_ack_i));

endmodule

`default_nettype wire

// File: dcache_rdata.sv
////////////////////////////////////////////////////////////////////////////
// read data path: line select, write buffer bypass, word select and
// read data register
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "dcache_consts.svh"

module dcache_rdata (
  input  wire logic                     clk_i,
  input  wire dcache_types_pkg::adr_t   adr_i,
  input  wire logic                     cacheable_i,
  input  wire logic                     cache_hit_i,
  input  wire logic                     in_biubuffer_i,
  input  wire dcache_types_pkg::line_t  biubuffer_i,
  input  wire dcache_types_pkg::line_t  cache_line_i,
  input  wire dcache_types_pkg::word_t  biu_q_i,
  input  wire logic                     filling_i,
  output dcache_types_pkg::word_t       q_o,
  wbuf_if.reader                        wb
);
  import dcache_types_pkg::*;

  offs_t offs;
  logic  bypass;
  line_t src_line;
  line_t wb_line;
  line_t merged_line;
  word_t cache_q;

  assign offs     = adr_i[`DC_BLK_OFFS_BITS-1 -: `DC_DAT_OFFS_BITS];
  assign bypass   = wb.we & (wb.idx == adr_i[`DC_BLK_OFFS_BITS +: `DC_IDX_BITS]);
  assign src_line = in_biubuffer_i ? biubuffer_i : cache_line_i;
  // buffered word copied to every slot, byte enables pick the right one
  assign wb_line  = {(`DC_BLK_BITS / `DC_XLEN){wb.data}};

  // overlay pending write bytes onto the line
  always_comb begin
    for (int i = 0; i < `DC_BLK_BITS / 8; i++) begin
      merged_line[i*8 +: 8] = (bypass && wb.be[i]) ? wb_line[i*8 +: 8] : src_line[i*8 +: 8];
    end
  end

  assign cache_q = merged_line[offs*`DC_XLEN +: `DC_XLEN];

  always_ff @(posedge clk_i) begin
    if (filling_i) begin
      q_o <= cache_hit_i ? cache_q : biu_q_i;
    end else begin
      q_o <= cacheable_i ? cache_q : biu_q_i;
    end
  end

endmodule

`default_nettype wire

// File: dcache_evict_buf.sv
////////////////////////////////////////////////////////////////////////////
// eviction buffer for the victim line and its address
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "dcache_consts.svh"

module dcache_evict_buf (
  input  wire logic                     clk_i,
  input  wire logic                     evict_capture_i,
  input  wire dcache_types_pkg::idx_t   evict_idx_i,
  input  wire dcache_types_pkg::tag_t   evict_tag_i,
  input  wire dcache_types_pkg::line_t  evict_line_i,
  output dcache_types_pkg::adr_t        evictbuffer_adr_o,
  output dcache_types_pkg::line_t       evictbuffer_line_o
);

  // frozen during the miss, memories are free for hit under miss
  always_ff @(posedge clk_i) begin
    if (evict_capture_i) begin
      evictbuffer_adr_o  <= {evict_tag_i, evict_idx_i, {`DC_BLK_OFFS_BITS{1'b0}}};
      evictbuffer_line_o <= evict_line_i;
    end
  end

endmodule

`default_nettype wire

// File: dcache_hit_top.sv
////////////////////////////////////////////////////////////////////////////
// data cache hit stage top level
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "dcache_consts.svh"

module dcache_hit_top (
  input  wire logic                       clk_i,
  input  wire logic                       rst_ni,
  input  wire logic                       flush_i,

  // core request
  input  wire logic                       req_i,
  input  wire logic                       wreq_i,
  input  wire logic                       cacheable_i,
  input  wire logic                       misaligned_i,
  input  wire logic                       pma_exception_i,
  input  wire logic                       pmp_exception_i,
  input  wire logic                       pagefault_i,
  input  wire dcache_types_pkg::adr_t     adr_i,
  input  wire dcache_types_pkg::word_t    d_i,
  input  wire dcache_types_pkg::word_be_t be_i,
  output dcache_types_pkg::word_t         q_o,
  output logic                            ack_o,
  output logic                            err_o,
  output logic                            misaligned_o,
  output logic                            pagefault_o,
  output logic                            stall_o,
  output logic                            armed_o,
  output logic                            filling_o,

  // cache memories
  input  wire logic                       cache_hit_i,
  input  wire dcache_types_pkg::way_t     ways_hit_i,
  input  wire dcache_types_pkg::line_t    cache_line_i,
  input  wire logic                       way_dirty_i,
  input  wire dcache_types_pkg::way_t     fill_way_i,
  output dcache_types_pkg::way_t          fill_way_o,
  output dcache_types_pkg::idx_t          idx_o,
  output dcache_types_pkg::tag_t          core_tag_o,
  output logic                            latchmem_o,

  // write buffer
  output logic                            writebuffer_we_o,
  input  wire logic                       writebuffer_ack_i,
  output dcache_types_pkg::idx_t          writebuffer_idx_o,
  output dcache_types_pkg::offs_t         writebuffer_offs_o,
  output dcache_types_pkg::word_t         writebuffer_data_o,
  output dcache_types_pkg::line_be_t      writebuffer_be_o,
  output dcache_types_pkg::way_t          writebuffer_ways_hit_o,

  // eviction
  input  wire dcache_types_pkg::idx_t     evict_idx_i,
  input  wire dcache_types_pkg::tag_t     evict_tag_i,
  input  wire dcache_types_pkg::line_t    evict_line_i,
  output dcache_types_pkg::adr_t          evictbuffer_adr_o,
  output dcache_types_pkg::line_t         evictbuffer_line_o,

  // bus interface
  output dcache_biu_pkg::biucmd_e         biucmd_o,
  input  wire logic                       biucmd_ack_i,
  input  wire logic                       biucmd_busy_i,
  input  wire dcache_types_pkg::word_t    biu_q_i,
  input  wire logic                       biu_ack_i,
  input  wire logic                       biu_err_i,
  input  wire dcache_types_pkg::adr_t     biu_adro_i,
  input  wire logic                       in_biubuffer_i,
  input  wire dcache_types_pkg::line_t    biubuffer_i
);

  logic wb_capture;
  logic evict_capture;

  wbuf_if wb ();

  // index and tag toward the tag and data memories
  assign idx_o      = adr_i[`DC_BLK_OFFS_BITS +: `DC_IDX_BITS];
  assign core_tag_o = adr_i[`DC_PLEN-1 -: `DC_TAG_BITS];

  assign writebuffer_we_o   = wb.we;
  assign writebuffer_idx_o  = wb.idx;
  assign writebuffer_offs_o = wb.offs;
  assign writebuffer_data_o = wb.data;
  assign writebuffer_be_o   = wb.be;

  dcache_hit_ctrl i_ctrl (
    .*,
    .wb_capture_o    (wb_capture),
    .evict_capture_o (evict_capture)
  );

  dcache_wbuf i_wbuf (
    .*,
    .wb_capture_i (wb_capture),
    .ways_hit_o   (writebuffer_ways_hit_o),
    .wb           (wb)
  );

  dcache_rdata i_rdata (
    .*,
    .filling_i (filling_o),
    .wb        (wb)
  );

  dcache_evict_buf i_evict_buf (
    .*,
    .evict_capture_i (evict_capture)
  );

endmodule

`default_nettype wire

// File: tb_dcache_hit.sv
////////////////////////////////////////////////////////////////////////////
// directed testbench for the data cache hit stage: clock, reset, bus
// model, test tasks, checks and timeout
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_dcache_hit;
  import dcache_types_pkg::*;
  import dcache_biu_pkg::*;

  localparam int MAX_CYCLES = 400;

  logic      clk_i;
  logic      rst_ni;
  logic      flush_i;
  logic      req_i;
  logic      wreq_i;
  logic      cacheable_i;
  logic      misaligned_i;
  logic      pma_exception_i;
  logic      pmp_exception_i;
  logic      pagefault_i;
  adr_t      adr_i;
  word_t     d_i;
  word_be_t  be_i;
  word_t     q_o;
  logic      ack_o;
  logic      err_o;
  logic      misaligned_o;
  logic      pagefault_o;
  logic      stall_o;
  logic      armed_o;
  logic      filling_o;
  logic      cache_hit_i;
  way_t      ways_hit_i;
  line_t     cache_line_i;
  logic      way_dirty_i;
  way_t      fill_way_i;
  way_t      fill_way_o;
  idx_t      idx_o;
  tag_t      core_tag_o;
  logic      latchmem_o;
  logic      writebuffer_we_o;
  logic      writebuffer_ack_i;
  idx_t      writebuffer_idx_o;
  offs_t     writebuffer_offs_o;
  word_t     writebuffer_data_o;
  line_be_t  writebuffer_be_o;
  way_t      writebuffer_ways_hit_o;
  idx_t      evict_idx_i;
  tag_t      evict_tag_i;
  line_t     evict_line_i;
  adr_t      evictbuffer_adr_o;
  line_t     evictbuffer_line_o;
  biucmd_e   biucmd_o;
  logic      biucmd_ack_i;
  logic      biucmd_busy_i;
  word_t     biu_q_i;
  logic      biu_ack_i;
  logic      biu_err_i;
  adr_t      biu_adro_i;
  logic      in_biubuffer_i;
  line_t     biubuffer_i;

  integer seed;
  int     errors;
  int     tests_run;
  int     tests_failed;
  int     ack_delay;
  int     cycles = 0;

  dcache_hit_top i_dut (.*);

  always #4 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // bus interface answers a read command after ack_delay cycles
  initial begin
    biucmd_ack_i = 1'b0;
    forever begin
      @(posedge clk_i);
      #1;
      if (biucmd_o == READWAY) begin
        repeat (ack_delay) @(posedge clk_i);
        #1;
        biucmd_ack_i = 1'b1;
        @(posedge clk_i);
        #1;
        biucmd_ack_i = 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////////
  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    assert (got === exp) else begin
      $display("Fail at %0t: %s is %b, expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_val(input string name, input logic [127:0] got,
                           input logic [127:0] exp);
    assert (got === exp) else begin
      $display("Fail at %0t: %s is %0h, expected %0h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int err_start);
    tests_run++;
    if (errors != err_start) begin
      tests_failed++;
      $display("test %s: %0d failing checks", name, errors - err_start);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  task automatic idle_inputs();
    req_i             = 1'b0;
    wreq_i            = 1'b0;
    flush_i           = 1'b0;
    cacheable_i       = 1'b0;
    misaligned_i      = 1'b0;
    pma_exception_i   = 1'b0;
    pmp_exception_i   = 1'b0;
    pagefault_i       = 1'b0;
    cache_hit_i       = 1'b0;
    way_dirty_i       = 1'b0;
    writebuffer_ack_i = 1'b0;
  endtask

  function automatic line_t rand_line();
    line_t l;
    for (int i = 0; i < 4; i++) begin
      l[32*i +: 32] = $random(seed);
    end
    return l;
  endfunction

  function automatic adr_t rand_adr();
    adr_t a;
    a = $random(seed);
    a[1:0] = 2'b00;
    return a;
  endfunction

  function automatic word_t word_at(input line_t line, input offs_t offs);
    int base;
    base = 32 * int'(offs);
    return line[base +: 32];
  endfunction

  // stay in the miss until the fill ends while stall holds
  task automatic wait_fill_done();
    int waited;
    waited = 0;
    while (filling_o && waited < 20) begin
      check_bit("stall_o", stall_o, 1'b1);
      check_bit("biucmd_o is WRITEWAY", biucmd_o == WRITEWAY, 1'b0);
      next_cycle();
      waited++;
    end
    assert (!filling_o) else begin
      $display("miss did not complete within 20 cycles at %0t", $time);
      errors++;
    end
  endtask

  task automatic wait_armed();
    int waited;
    waited = 0;
    while (!armed_o && waited < 10) begin
      next_cycle();
      waited++;
    end
    assert (armed_o) else begin
      $display("stage did not return to armed at %0t", $time);
      errors++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////////
  task automatic reset_values_test();
    int err0;
    err0 = errors;
    check_bit("ack_o", ack_o, 1'b0);
    check_bit("writebuffer_we_o", writebuffer_we_o, 1'b0);
    check_bit("stall_o", stall_o, 1'b0);
    check_bit("armed_o", armed_o, 1'b1);
    check_bit("filling_o", filling_o, 1'b0);
    check_val("biucmd_o", 128'(biucmd_o), 128'(NOP));
    report_test("reset values", err0);
  endtask

  task automatic read_hit_test();
    int    err0;
    line_t line;
    word_t exp_q;
    err0 = errors;
    next_cycle();
    line         = rand_line();
    cache_line_i = line;
    adr_i        = rand_adr();
    req_i        = 1'b1;
    cacheable_i  = 1'b1;
    cache_hit_i  = 1'b1;
    exp_q        = word_at(line, adr_i[3:2]);
    #1;
    check_bit("stall_o", stall_o, 1'b0);
    check_val("idx_o", 128'(idx_o), 128'(adr_i[7:4]));
    check_val("core_tag_o", 128'(core_tag_o), 128'(adr_i[31:8]));
    next_cycle();
    check_bit("ack_o", ack_o, 1'b1);
    check_val("q_o", 128'(q_o), 128'(exp_q));
    idle_inputs();
    report_test("read hit", err0);
  endtask

  task automatic write_hit_test();
    int       err0;
    line_t    line;
    line_t    exp_line;
    line_be_t exp_be;
    word_t    data;
    word_be_t be;
    offs_t    offs;
    way_t     ways;
    err0 = errors;
    next_cycle();
    adr_i       = rand_adr();
    offs        = adr_i[3:2];
    data        = $random(seed);
    be          = word_be_t'($random(seed)) | 4'b0001;
    ways        = ($random(seed) & 1) ? 2'b10 : 2'b01;
    d_i         = data;
    be_i        = be;
    ways_hit_i  = ways;
    req_i       = 1'b1;
    wreq_i      = 1'b1;
    cacheable_i = 1'b1;
    cache_hit_i = 1'b1;
    // four enable bits per word slot of the line
    exp_be = '0;
    for (int j = 0; j < 4; j++) begin
      exp_be[4*int'(offs) + j] = be[j];
    end
    next_cycle();
    check_bit("writebuffer_we_o", writebuffer_we_o, 1'b1);
    check_val("writebuffer_idx_o", 128'(writebuffer_idx_o), 128'(adr_i[7:4]));
    check_val("writebuffer_offs_o", 128'(writebuffer_offs_o), 128'(offs));
    check_val("writebuffer_data_o", 128'(writebuffer_data_o), 128'(data));
    check_val("writebuffer_be_o", 128'(writebuffer_be_o), 128'(exp_be));
    check_val("writebuffer_ways_hit_o", 128'(writebuffer_ways_hit_o), 128'(ways));
    // read back the same word from a fresh line
    wreq_i       = 1'b0;
    d_i          = '0;
    line         = rand_line();
    cache_line_i = line;
    exp_line     = line;
    for (int j = 0; j < 4; j++) begin
      if (be[j]) begin
        exp_line[32*int'(offs) + 8*j +: 8] = data[8*j +: 8];
      end
    end
    next_cycle();
    check_bit("ack_o", ack_o, 1'b1);
    check_val("q_o", 128'(q_o), 128'(word_at(exp_line, offs)));
    check_bit("writebuffer_we_o", writebuffer_we_o, 1'b1);
    idle_inputs();
    writebuffer_ack_i = 1'b1;
    next_cycle();
    check_bit("writebuffer_we_o", writebuffer_we_o, 1'b0);
    writebuffer_ack_i = 1'b0;
    report_test("write hit and bypass", err0);
  endtask

  task automatic clean_miss_test();
    int   err0;
    way_t way;
    err0      = errors;
    ack_delay = 3;
    next_cycle();
    way         = 2'b10;
    fill_way_i  = way;
    adr_i       = rand_adr();
    req_i       = 1'b1;
    cacheable_i = 1'b1;
    #1;
    check_bit("stall_o", stall_o, 1'b1);
    check_bit("latchmem_o", latchmem_o, 1'b0);
    next_cycle();
    check_bit("filling_o", filling_o, 1'b1);
    check_bit("armed_o", armed_o, 1'b0);
    check_val("biucmd_o", 128'(biucmd_o), 128'(READWAY));
    check_val("fill_way_o", 128'(fill_way_o), 128'(way));
    fill_way_i = 2'b01;
    next_cycle();
    check_val("biucmd_o", 128'(biucmd_o), 128'(NOP));
    wait_fill_done();
    req_i = 1'b0;
    #1;
    // first recovery cycle
    check_bit("stall_o", stall_o, 1'b1);
    check_bit("latchmem_o", latchmem_o, 1'b0);
    check_val("fill_way_o", 128'(fill_way_o), 128'(way));
    // a clean victim needs no write back
    check_val("biucmd_o", 128'(biucmd_o), 128'(NOP));
    next_cycle();
    check_bit("stall_o", stall_o, 1'b1);
    check_bit("latchmem_o", latchmem_o, 1'b1);
    check_bit("armed_o", armed_o, 1'b0);
    next_cycle();
    check_bit("armed_o", armed_o, 1'b1);
    check_bit("stall_o", stall_o, 1'b0);
    idle_inputs();
    report_test("clean miss", err0);
  endtask

  task automatic dirty_miss_test();
    int    err0;
    line_t victim_line;
    tag_t  victim_tag;
    idx_t  victim_idx;
    err0        = errors;
    ack_delay   = 2;
    next_cycle();
    victim_line  = rand_line();
    victim_tag   = tag_t'($random(seed));
    victim_idx   = idx_t'($random(seed));
    evict_line_i = victim_line;
    evict_tag_i  = victim_tag;
    evict_idx_i  = victim_idx;
    fill_way_i   = 2'b01;
    adr_i        = rand_adr();
    req_i        = 1'b1;
    cacheable_i  = 1'b1;
    way_dirty_i  = 1'b1;
    next_cycle();
    check_val("biucmd_o", 128'(biucmd_o), 128'(READWAY));
    check_bit("filling_o", filling_o, 1'b1);
    check_val("evictbuffer_adr_o", 128'(evictbuffer_adr_o),
              128'({victim_tag, victim_idx, 4'b0000}));
    check_val("evictbuffer_line_o", evictbuffer_line_o, victim_line);
    // memories move on while the victim stays frozen
    evict_line_i = rand_line();
    evict_tag_i  = tag_t'($random(seed));
    evict_idx_i  = idx_t'($random(seed));
    way_dirty_i  = 1'b0;
    next_cycle();
    wait_fill_done();
    check_val("biucmd_o", 128'(biucmd_o), 128'(WRITEWAY));
    req_i = 1'b0;
    next_cycle();
    check_val("biucmd_o", 128'(biucmd_o), 128'(NOP));
    check_val("evictbuffer_adr_o", 128'(evictbuffer_adr_o),
              128'({victim_tag, victim_idx, 4'b0000}));
    check_val("evictbuffer_line_o", evictbuffer_line_o, victim_line);
    wait_armed();
    idle_inputs();
    report_test("dirty miss", err0);
  endtask

  task automatic exceptions_test();
    int err0;
    err0 = errors;
    next_cycle();
    adr_i           = rand_adr();
    req_i           = 1'b1;
    wreq_i          = 1'b1;
    cacheable_i     = 1'b1;
    cache_hit_i     = 1'b1;
    pmp_exception_i = 1'b1;
    next_cycle();
    check_bit("err_o", err_o, 1'b1);
    check_bit("ack_o", ack_o, 1'b0);
    check_bit("writebuffer_we_o", writebuffer_we_o, 1'b0);
    pmp_exception_i = 1'b0;
    misaligned_i    = 1'b1;
    next_cycle();
    check_bit("misaligned_o", misaligned_o, 1'b1);
    check_bit("err_o", err_o, 1'b0);
    check_bit("ack_o", ack_o, 1'b0);
    check_bit("writebuffer_we_o", writebuffer_we_o, 1'b0);
    misaligned_i = 1'b0;
    pagefault_i  = 1'b1;
    next_cycle();
    check_bit("pagefault_o", pagefault_o, 1'b1);
    check_bit("misaligned_o", misaligned_o, 1'b0);
    check_bit("ack_o", ack_o, 1'b0);
    check_bit("writebuffer_we_o", writebuffer_we_o, 1'b0);
    idle_inputs();
    next_cycle();
    check_bit("pagefault_o", pagefault_o, 1'b0);
    report_test("exceptions", err0);
  endtask

  task automatic flush_test();
    int err0;
    err0 = errors;
    next_cycle();
    adr_i       = rand_adr();
    req_i       = 1'b1;
    cacheable_i = 1'b1;
    cache_hit_i = 1'b1;
    flush_i     = 1'b1;
    next_cycle();
    check_bit("ack_o", ack_o, 1'b0);
    flush_i = 1'b0;
    wreq_i  = 1'b1;
    d_i     = $random(seed);
    be_i    = 4'hf;
    next_cycle();
    check_bit("writebuffer_we_o", writebuffer_we_o, 1'b1);
    idle_inputs();
    flush_i = 1'b1;
    next_cycle();
    check_bit("writebuffer_we_o", writebuffer_we_o, 1'b0);
    flush_i = 1'b0;
    report_test("pipeline flush", err0);
  endtask

  //////////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////////
  initial begin
    seed           = 77202;
    errors         = 0;
    tests_run      = 0;
    tests_failed   = 0;
    ack_delay      = 1;
    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    idle_inputs();
    adr_i          = '0;
    d_i            = '0;
    be_i           = '0;
    ways_hit_i     = '0;
    cache_line_i   = '0;
    fill_way_i     = '0;
    evict_idx_i    = '0;
    evict_tag_i    = '0;
    evict_line_i   = '0;
    biucmd_busy_i  = 1'b0;
    biu_q_i        = '0;
    biu_ack_i      = 1'b0;
    biu_err_i      = 1'b0;
    biu_adro_i     = '0;
    in_biubuffer_i = 1'b0;
    biubuffer_i    = '0;
    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    #1;

    reset_values_test();
    read_hit_test();
    write_hit_test();
    clean_miss_test();
    dirty_miss_test();
    exceptions_test();
    flush_test();

    $display("tests run %0d, tests failing %0d, failed checks %0d",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+.
dcache_types_pkg.sv
dcache_biu_pkg.sv
wbuf_if.sv
dcache_hit_ctrl.sv
dcache_wbuf.sv
dcache_rdata.sv
dcache_evict_buf.sv
dcache_hit_top.sv
tb_dcache_hit.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, and search the output for the pass message
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -f project.f --top-module tb_dcache_hit \
  && ./obj_dir/Vtb_dcache_hit | tee /dev/stderr | grep -q "ALL CHECKS PASSED" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
